//--- bench/tb_clock_gen.sv
// Clock and reset source of the wide memory testbench.
// Reset is held low for the first RST_CYCLES rising edges.
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    // Released on an edge, like any synchronous input.
    rst_n_o <= 1'b1;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

//--- bench/wide_mem_tb_table.svh
// Test table of the wide memory testbench, included inside its top module.
// Request columns: we, addr, wdata, strb.
// Row columns: busy mask, busy cycles, random busy flag, request count.
// Each row takes the next count requests of the request list.
// In a random row the busy mask is ANDed with LFSR bits every cycle,
// and write data comes from the LFSR instead of the wdata column.
`ifndef WIDE_MEM_TB_TABLE_SVH
`define WIDE_MEM_TB_TABLE_SVH

typedef struct packed {
  logic                     we;
  wide_mem_pkg::addr_t      addr;
  wide_mem_pkg::wide_data_t wdata;
  wide_mem_pkg::wide_strb_t strb;
} wreq_t;

typedef struct packed {
  wide_mem_pkg::bank_mask_t busy;
  logic [7:0]               cycles;
  logic                     rnd;
  logic [3:0]               count;
} row_t;

localparam int NUM_ROWS = 5;
localparam int NUM_REQS = 19;

localparam row_t ROW_TBL [NUM_ROWS] = '{
  '{4'b0000, 8'd0,  1'b0, 4'd2},  // Write and read back after reset.
  '{4'b0000, 8'd0,  1'b0, 4'd3},  // Partial strobe merge.
  '{4'b0110, 8'd6,  1'b0, 4'd2},  // Zero-strobe lanes held busy.
  '{4'b0010, 8'd12, 1'b0, 4'd5},  // One lane busy, grant must stall.
  '{4'b1111, 8'd30, 1'b1, 4'd7}   // Random busy, outstanding limit.
};

localparam wreq_t REQ_TBL [NUM_REQS] = '{
  '{1'b1, 12'h040, 64'h0123_4567_89ab_cdef, 8'hff},
  '{1'b0, 12'h040, 64'h0, 8'h00},
  '{1'b1, 12'h088, 64'h1111_2222_3333_4444, 8'hff},
  '{1'b1, 12'h08a, 64'ha5a5_a5a5_a5a5_a5a5, 8'h5a},
  '{1'b0, 12'h088, 64'h0, 8'h00},
  '{1'b1, 12'h040, 64'hfedc_ba98_7654_3210, 8'hc3},
  '{1'b0, 12'h040, 64'h0, 8'h00},
  '{1'b0, 12'h040, 64'h0, 8'h00},
  '{1'b0, 12'h088, 64'h0, 8'h00},
  '{1'b0, 12'h040, 64'h0, 8'h00},
  '{1'b0, 12'h088, 64'h0, 8'h00},
  '{1'b0, 12'h040, 64'h0, 8'h00},
  '{1'b1, 12'h100, 64'h0, 8'hff},
  '{1'b0, 12'h100, 64'h0, 8'h00},
  '{1'b0, 12'h040, 64'h0, 8'h00},
  '{1'b0, 12'h088, 64'h0, 8'h00},
  '{1'b0, 12'h100, 64'h0, 8'h00},
  '{1'b0, 12'h040, 64'h0, 8'h00},
  '{1'b0, 12'h088, 64'h0, 8'h00}
};

`endif

//--- bench/wide_mem_tb.sv
// Testbench of the wide memory port.
// Applies the test table to the DUT, checks every response against a
// byte-wide reference memory and the port's latency and ordering rules.
`timescale 1ns/1ps

module wide_mem_tb;

  localparam int          CLK_PERIOD = 40;
  localparam int          ROW_CYCLES = 60;
  localparam logic [15:0] LFSR_SEED  = 16'd70;

  `include "wide_mem_tb_table.svh"

  // Reset cycles plus a fixed budget per table row.
  localparam int CYCLE_LIMIT = NUM_ROWS * ROW_CYCLES + 10;

  // One expected response in acceptance order.
  typedef struct packed {
    logic        rd;
    logic        prompt;
    logic [31:0] cyc;
    logic [63:0] data;
  } exp_t;

  logic                     clk;
  logic                     rst_n;
  logic                     req;
  logic                     gnt;
  logic                     we;
  logic                     rvalid;
  wide_mem_pkg::addr_t      addr;
  wide_mem_pkg::wide_data_t wdata;
  wide_mem_pkg::wide_data_t rdata;
  wide_mem_pkg::wide_strb_t strb;
  wide_mem_pkg::bank_mask_t bank_busy;

  exp_t        exp_q [$];
  logic [7:0]  ref_mem [4096];
  logic [15:0] lfsr_q      = LFSR_SEED;
  int          cycle_cnt   = 0;
  int          rvalid_seen = 0;
  int          errors      = 0;
  int          checks      = 0;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  wide_mem_top wide_mem_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .gnt_o       (gnt),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .strb_i      (strb),
    .we_i        (we),
    .rvalid_o    (rvalid),
    .rdata_o     (rdata),
    .bank_busy_i (bank_busy)
  );

  // Run length guard.
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d responses missing", cycle_cnt, exp_q.size());
      $display("sim failed");
      $finish;
    end
  end

  // Every response pulse, also those between table rows.
  always @(negedge clk) begin
    if (rvalid)
      rvalid_seen <= rvalid_seen + 1;
  end

  // Fibonacci LFSR with the taps of x^16 + x^14 + x^13 + x^11 + 1.
  // One step for each bit returned.
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[62:0], fb};
    end
    return v;
  endfunction

  // Write lanes with an empty strobe slice give no bank response.
  function automatic logic [3:0] dead_lanes(input logic w, input logic [7:0] s);
    logic [3:0] m;
    for (int i = 0; i < 4; i++)
      m[i] = w & (s[2*i +: 2] == 2'b00);
    return m;
  endfunction

  // Reference model works on the aligned wide word.
  function automatic logic [63:0] ref_read(input logic [11:0] a);
    logic [63:0] v;
    for (int j = 0; j < 8; j++)
      v[j*8 +: 8] = ref_mem[{a[11:3], 3'b000} + j];
    return v;
  endfunction

  task automatic ref_write(input logic [11:0] a, input logic [63:0] d, input logic [7:0] s);
    for (int j = 0; j < 8; j++)
      if (s[j])
        ref_mem[{a[11:3], 3'b000} + j] = d[j*8 +: 8];
  endtask

  task automatic check_response();
    exp_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("response arrived with no request outstanding");
    end else begin
      e = exp_q.pop_front();
      checks++;
      if (e.rd && rdata !== e.data) begin
        errors++;
        $display("[ERROR] rdata_o: got %h, expected %h", rdata, e.data);
      end
      if (e.prompt && cycle_cnt != e.cyc + 1) begin
        errors++;
        $display("response took %0d cycles where one was expected", cycle_cnt - e.cyc);
      end
    end
  endtask

  // An idle port with no busy live lane answers in the next cycle.
  task automatic accept_request();
    exp_t e;
    e.rd     = !we;
    e.cyc    = cycle_cnt;
    e.prompt = (exp_q.size() == 0) && ((bank_busy & ~dead_lanes(we, strb)) == '0);
    e.data   = '0;
    if (we)
      ref_write(addr, wdata, strb);
    else
      e.data = ref_read(addr);
    exp_q.push_back(e);
    checks++;
    if (exp_q.size() > wide_mem_pkg::MAX_TRANS) begin
      errors++;
      $display("more than %0d requests outstanding", wide_mem_pkg::MAX_TRANS);
    end
  endtask

  // Fields of a pending request stay put until it is granted.
  task automatic drive_inputs(input int r, input int idx, input logic more,
                              input logic load, input int busy_left);
    wreq_t q;
    if (busy_left == 0)
      bank_busy <= '0;
    else if (ROW_TBL[r].rnd)
      bank_busy <= ROW_TBL[r].busy & 4'(lfsr_bits(4));
    else
      bank_busy <= ROW_TBL[r].busy;
    if (load && more) begin
      q = REQ_TBL[idx];
      req  <= 1'b1;
      we   <= q.we;
      addr <= q.addr;
      strb <= q.strb;
      if (ROW_TBL[r].rnd && q.we)
        wdata <= lfsr_bits(64);
      else
        wdata <= q.wdata;
    end else if (load) begin
      req <= 1'b0;
    end
  endtask

  task automatic run_row(input int r, input int first);
    int   sent;
    int   busy_left;
    int   row_errors;
    int   resp_cnt;
    logic load;
    logic stalled;
    logic done;
    sent       = 0;
    busy_left  = ROW_TBL[r].cycles;
    row_errors = errors;
    resp_cnt   = 0;
    stalled    = 1'b0;
    @(posedge clk);
    drive_inputs(r, first, 1'b1, 1'b1, busy_left);
    do begin
      // Outputs are sampled mid-cycle while inputs change on the rising edge.
      @(negedge clk);
      if (rvalid) begin
        resp_cnt++;
        check_response();
      end
      if (req && !gnt)
        stalled = 1'b1;
      load = req & gnt;
      if (load) begin
        accept_request();
        sent++;
      end
      done = (sent == ROW_TBL[r].count) && (exp_q.size() == 0) && (busy_left <= 1);
      @(posedge clk);
      if (busy_left > 0)
        busy_left--;
      drive_inputs(r, first + sent, sent < ROW_TBL[r].count, load, busy_left);
    end while (!done);
    // A long burst against a fixed busy lane must run into the limit.
    if (ROW_TBL[r].busy != '0 && !ROW_TBL[r].rnd &&
        ROW_TBL[r].count > wide_mem_pkg::MAX_TRANS) begin
      checks++;
      if (!stalled) begin
        errors++;
        $display("gnt_o never dropped while a bank was held busy");
      end
    end
    $display("test %0d: %0d requests, %0d responses, %0d errors", r, ROW_TBL[r].count,
             resp_cnt, errors - row_errors);
  endtask

  initial begin
    int first;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    strb      = '0;
    bank_busy = '0;
    first     = 0;
    wait (rst_n);
    @(negedge clk);
    checks++;
    if (gnt !== 1'b1) begin
      errors++;
      $display("[ERROR] gnt_o after reset: got %h, expected 1", gnt);
    end
    if (rvalid !== 1'b0) begin
      errors++;
      $display("[ERROR] rvalid_o after reset: got %h, expected 0", rvalid);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r, first);
      first += ROW_TBL[r].count;
    end
    // Trailing cycles stay quiet, so every request got exactly one pulse.
    repeat (2) @(posedge clk);
    checks++;
    if (rvalid_seen != NUM_REQS) begin
      errors++;
      $display("rvalid_o pulsed %0d times for %0d accepted requests", rvalid_seen, NUM_REQS);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- verilog/bank_req_fifo.sv
// Fall-through request FIFO of one bank lane.
// A write whose strobe slice is zero leaves the head without ever
// reaching the bank, everything else waits there for the bank grant.
`timescale 1ns/1ps

module bank_req_fifo #(
  parameter int unsigned DEPTH = wide_mem_pkg::FIFO_DEPTH
) (
  input logic       clk_i,
  input logic       rst_n_i,
  bank_req_if.fifo  lane
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Payload storage.
  wide_mem_pkg::addr_t      addr_mem  [DEPTH];
  wide_mem_pkg::bank_data_t wdata_mem [DEPTH];
  wide_mem_pkg::bank_strb_t strb_mem  [DEPTH];
  logic                     we_mem    [DEPTH];

  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     cnt;
  logic               empty;
  logic               head_valid;
  logic               head_dead;
  logic               pop;
  logic               do_write;
  logic               do_read;

  assign empty      = (cnt == '0);
  assign lane.ready = (cnt != DEPTH);

  // Head comes straight from the push side when nothing is stored.
  assign head_valid = !empty | lane.push;
  assign lane.addr  = empty ? lane.push_addr  : addr_mem[rd_ptr];
  assign lane.wdata = empty ? lane.push_wdata : wdata_mem[rd_ptr];
  assign lane.strb  = empty ? lane.push_strb  : strb_mem[rd_ptr];
  assign lane.we    = empty ? lane.push_we    : we_mem[rd_ptr];

  // Zero-strobe write at the head retires on its own.
  assign head_dead = lane.we & (lane.strb == '0);
  assign lane.req  = head_valid & !head_dead;
  assign pop       = head_valid & (head_dead | lane.gnt);

  // A push into an empty FIFO that leaves at once is never stored.
  assign do_write = lane.push & !(empty & pop);
  assign do_read  = pop & !empty;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (do_write && !do_read) begin
        cnt <= cnt + 1'b1;
      end else if (do_read && !do_write) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      addr_mem[wr_ptr]  <= lane.push_addr;
      wdata_mem[wr_ptr] <= lane.push_wdata;
      strb_mem[wr_ptr]  <= lane.push_strb;
      we_mem[wr_ptr]    <= lane.push_we;
    end
  end

  // The wide grant must hold back pushes into a full lane.
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    lane.push |-> lane.ready
  ) else $error("push into full request FIFO");

endmodule

//--- verilog/bank_req_if.sv
// Request and response signals of one bank lane.
// The top level fills the push side, the request FIFO drives the bank request,
// and the bank answers on the response side.
`timescale 1ns/1ps

interface bank_req_if;

  // Push side, driven from the wide request split.
  logic                     push;
  logic                     ready;
  wide_mem_pkg::addr_t      push_addr;
  wide_mem_pkg::bank_data_t push_wdata;
  wide_mem_pkg::bank_strb_t push_strb;
  logic                     push_we;

  // Bank request, driven from the FIFO head.
  logic                     req;
  logic                     gnt;
  wide_mem_pkg::addr_t      addr;
  wide_mem_pkg::bank_data_t wdata;
  wide_mem_pkg::bank_strb_t strb;
  logic                     we;

  // Bank response.
  logic                     rvalid;
  wide_mem_pkg::bank_data_t rdata;

  modport split (output push, push_addr, push_wdata, push_strb, push_we,
                 input ready, rvalid, rdata);
  modport fifo (output ready, req, addr, wdata, strb, we,
                input push, push_addr, push_wdata, push_strb, push_we, gnt);
  modport bank (output gnt, rvalid, rdata,
                input req, addr, wdata, strb, we);

endinterface

//--- verilog/bank_resp_fifo.sv
// Fall-through response FIFO of one bank lane.
// Holds bank answers until all lanes of a wide request can be joined.
`timescale 1ns/1ps

module bank_resp_fifo #(
  parameter int unsigned DEPTH = wide_mem_pkg::FIFO_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     rvalid_i,
  input  wide_mem_pkg::bank_data_t rdata_i,
  output logic                     ready_o,
  output logic                     valid_o,
  output wide_mem_pkg::bank_data_t rdata_o,
  input  logic                     pop_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  wide_mem_pkg::bank_data_t data_mem [DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W:0]           cnt;
  logic                     empty;
  logic                     do_write;
  logic                     do_read;

  assign empty   = (cnt == '0);
  assign ready_o = (cnt != DEPTH);

  // Bank answer is visible in the cycle it arrives.
  assign valid_o = !empty | rvalid_i;
  assign rdata_o = empty ? rdata_i : data_mem[rd_ptr];

  assign do_write = rvalid_i & !(empty & pop_i);
  assign do_read  = pop_i & !empty;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (do_write && !do_read) begin
        cnt <= cnt + 1'b1;
      end else if (do_read && !do_write) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      data_mem[wr_ptr] <= rdata_i;
    end
  end

  // Outstanding limit at the wide port keeps this FIFO from overflowing.
  a_no_resp_full : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> ready_o
  ) else $error("bank response into full response FIFO");

endmodule

//--- verilog/bank_split_ctrl.sv
// Control of the wide port for grant, lane push and response join.
// A small queue remembers, per accepted request, which lanes give no bank
// response, so the join can complete those lanes without waiting.
`timescale 1ns/1ps

module bank_split_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  output logic                     gnt_o,
  input  wide_mem_pkg::bank_mask_t zero_mask_i,
  input  wide_mem_pkg::bank_mask_t lane_ready_i,
  input  wide_mem_pkg::bank_mask_t resp_valid_i,
  input  wide_mem_pkg::bank_mask_t resp_ready_i,
  output wide_mem_pkg::bank_mask_t push_o,
  output wide_mem_pkg::bank_mask_t pop_o,
  output logic                     rvalid_o
);

  // Dead-slot queue pointers and fill level.
  logic [$clog2(wide_mem_pkg::MAX_TRANS)-1:0]   dq_wr_ptr;
  logic [$clog2(wide_mem_pkg::MAX_TRANS)-1:0]   dq_rd_ptr;
  logic [$clog2(wide_mem_pkg::MAX_TRANS+1)-1:0] dq_cnt;
  wide_mem_pkg::bank_mask_t                     dq_mem [wide_mem_pkg::MAX_TRANS];
  wide_mem_pkg::bank_mask_t                     dq_head;
  logic                                         dq_full;
  logic                                         dq_empty;
  logic                                         accept;

  // Pointer step with wrap at the queue depth.
  function automatic logic [$clog2(wide_mem_pkg::MAX_TRANS)-1:0] next_ptr(
    input logic [$clog2(wide_mem_pkg::MAX_TRANS)-1:0] ptr
  );
    if (ptr == wide_mem_pkg::MAX_TRANS - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign dq_full  = (dq_cnt == wide_mem_pkg::MAX_TRANS);
  assign dq_empty = (dq_cnt == '0);
  assign dq_head  = dq_mem[dq_rd_ptr];

  // Grant only if every lane can take the split request and its response.
  assign gnt_o  = (&lane_ready_i) & (&resp_ready_i) & !dq_full;
  assign accept = req_i & gnt_o;

  // All lanes are loaded together.
  assign push_o = {wide_mem_pkg::NUM_BANKS{accept}};

  // Each lane is either holding data or marked dead for the head request.
  assign rvalid_o = !dq_empty & (&(resp_valid_i | dq_head));

  // Dead lanes hold nothing in their response FIFO.
  assign pop_o = {wide_mem_pkg::NUM_BANKS{rvalid_o}} & ~dq_head;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dq_wr_ptr <= '0;
      dq_rd_ptr <= '0;
      dq_cnt    <= '0;
    end else begin
      if (accept) begin
        dq_wr_ptr <= next_ptr(dq_wr_ptr);
      end
      if (rvalid_o) begin
        dq_rd_ptr <= next_ptr(dq_rd_ptr);
      end
      case ({accept, rvalid_o})
        2'b10:   dq_cnt <= dq_cnt + 1'b1;
        2'b01:   dq_cnt <= dq_cnt - 1'b1;
        default: dq_cnt <= dq_cnt;
      endcase
    end
  end

  // Zero-slot mask of each accepted request.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dq_mem[dq_wr_ptr] <= zero_mask_i;
    end
  end

  // No lane may hold a response while nothing is outstanding.
  // Bank answers belong to accepted requests only.
  a_no_resp_when_idle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    dq_empty |-> (resp_valid_i == '0)
  ) else $error("response data present with no outstanding request");

endmodule

//--- verilog/sram_bank.sv
// On-chip SRAM model of one 16-bit bank with byte strobes.
// Grants whenever the external busy input is low and answers
// every granted access one cycle later.
`timescale 1ns/1ps

module sram_bank (
  input logic       clk_i,
  input logic       rst_n_i,
  // Another port holds the bank.
  input logic       busy_i,
  bank_req_if.bank  port
);

  wide_mem_pkg::bank_data_t                      mem [wide_mem_pkg::BANK_WORDS];
  logic [wide_mem_pkg::ADDR_W-4:0]               word_idx;
  logic                                          accept;
  logic                                          rvalid_q;
  wide_mem_pkg::bank_data_t                      rdata_q;

  // Word index skips the byte offset inside the wide word.
  assign word_idx = port.addr[wide_mem_pkg::ADDR_W-1:3];

  assign port.gnt = !busy_i;
  assign accept   = port.req & port.gnt;

  // One response per granted access.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  // Array access and read data.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (port.we) begin
        // Only strobed bytes change.
        for (int b = 0; b < wide_mem_pkg::BANK_STRB_W; b++) begin
          if (port.strb[b]) begin
            mem[word_idx][b*8 +: 8] <= port.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign port.rvalid = rvalid_q;
  assign port.rdata  = rdata_q;

endmodule

//--- verilog/wide_mem_pkg.sv
// Shared widths, depths and vector types for the wide memory port.
// Every design file refers to these by scoped names.

package wide_mem_pkg;

  // Byte address width of the wide port.
  localparam int unsigned ADDR_W = 12;
  // Wide data width seen by the requester.
  localparam int unsigned DATA_W = 64;
  // Number of narrow banks behind the port.
  localparam int unsigned NUM_BANKS = 4;
  // Each bank carries one equal slice of the wide word.
  localparam int unsigned BANK_DATA_W = DATA_W / NUM_BANKS;
  // One strobe bit per byte.
  localparam int unsigned BANK_STRB_W = BANK_DATA_W / 8;
  localparam int unsigned WIDE_STRB_W = DATA_W / 8;
  // Bank word index is taken from the address above the wide byte offset.
  localparam int unsigned BANK_WORDS = 2 ** (ADDR_W - 3);
  // Depth of both the request and the response FIFO of a lane.
  localparam int unsigned FIFO_DEPTH = 3;
  // Wide requests in flight, also the dead-slot queue depth.
  localparam int unsigned MAX_TRANS = 3;

  // Byte address.
  typedef logic [ADDR_W-1:0] addr_t;

  // Wide data and strobe.
  typedef logic [DATA_W-1:0] wide_data_t;
  typedef logic [WIDE_STRB_W-1:0] wide_strb_t;

  // Per-bank data and strobe.
  typedef logic [BANK_DATA_W-1:0] bank_data_t;
  typedef logic [BANK_STRB_W-1:0] bank_strb_t;

  // One bit per bank lane.
  typedef logic [NUM_BANKS-1:0] bank_mask_t;

endpackage

//--- verilog/wide_mem_top.sv
// Wide 64-bit memory port served by four 16-bit SRAM banks.
// Each request is split into one bank request per lane, and the lane
// responses are joined back in request order.
`timescale 1ns/1ps

module wide_mem_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  output logic                     gnt_o,
  input  wide_mem_pkg::addr_t      addr_i,
  input  wide_mem_pkg::wide_data_t wdata_i,
  input  wide_mem_pkg::wide_strb_t strb_i,
  input  logic                     we_i,
  output logic                     rvalid_o,
  output wide_mem_pkg::wide_data_t rdata_o,
  input  wide_mem_pkg::bank_mask_t bank_busy_i
);

  wide_mem_pkg::addr_t      aligned_addr;
  wide_mem_pkg::bank_mask_t zero_mask;
  wide_mem_pkg::bank_mask_t lane_ready;
  wide_mem_pkg::bank_mask_t resp_valid;
  wide_mem_pkg::bank_mask_t resp_ready;
  wide_mem_pkg::bank_mask_t lane_push;
  wide_mem_pkg::bank_mask_t lane_pop;

  bank_req_if lane_if [wide_mem_pkg::NUM_BANKS] ();

  // Drop the byte offset within the wide word.
  assign aligned_addr = {addr_i[wide_mem_pkg::ADDR_W-1:3], 3'b000};

  for (genvar i = 0; i < wide_mem_pkg::NUM_BANKS; i++) begin : gen_lane
    // Lane i serves bytes 2*i and 2*i+1 of the wide word.
    assign lane_if[i].push       = lane_push[i];
    assign lane_if[i].push_addr  =
      wide_mem_pkg::addr_t'(aligned_addr + i * wide_mem_pkg::BANK_STRB_W);
    assign lane_if[i].push_wdata =
      wdata_i[i*wide_mem_pkg::BANK_DATA_W +: wide_mem_pkg::BANK_DATA_W];
    assign lane_if[i].push_strb  =
      strb_i[i*wide_mem_pkg::BANK_STRB_W +: wide_mem_pkg::BANK_STRB_W];
    assign lane_if[i].push_we    = we_i;

    // Write slots with no strobe never reach the bank.
    assign zero_mask[i]  = we_i & (lane_if[i].push_strb == '0);
    assign lane_ready[i] = lane_if[i].ready;

    bank_req_fifo #(.DEPTH(wide_mem_pkg::FIFO_DEPTH)) i_req_fifo (
      .clk_i,
      .rst_n_i,
      .lane (lane_if[i])
    );

    sram_bank i_bank (
      .clk_i,
      .rst_n_i,
      .busy_i (bank_busy_i[i]),
      .port   (lane_if[i])
    );

    bank_resp_fifo #(.DEPTH(wide_mem_pkg::FIFO_DEPTH)) i_resp_fifo (
      .clk_i,
      .rst_n_i,
      .rvalid_i (lane_if[i].rvalid),
      .rdata_i  (lane_if[i].rdata),
      .ready_o  (resp_ready[i]),
      .valid_o  (resp_valid[i]),
      .rdata_o  (rdata_o[i*wide_mem_pkg::BANK_DATA_W +: wide_mem_pkg::BANK_DATA_W]),
      .pop_i    (lane_pop[i])
    );
  end

  bank_split_ctrl i_ctrl (
    .clk_i,
    .rst_n_i,
    .req_i,
    .gnt_o,
    .zero_mask_i  (zero_mask),
    .lane_ready_i (lane_ready),
    .resp_valid_i (resp_valid),
    .resp_ready_i (resp_ready),
    .push_o       (lane_push),
    .pop_o        (lane_pop),
    .rvalid_o
  );

endmodule

//--- wide_mem.f
+incdir+bench
verilog/wide_mem_pkg.sv
verilog/bank_req_if.sv
verilog/bank_split_ctrl.sv
verilog/bank_req_fifo.sv
verilog/bank_resp_fifo.sv
verilog/sram_bank.sv
verilog/wide_mem_top.sv
bench/tb_clock_gen.sv
bench/wide_mem_tb.sv
